// File: logic/ptw_consts.svh
// ----------------------------------------------------------
// Sv39 walker constants: widths and field positions
// ----------------------------------------------------------
`ifndef PTW_CONSTS_SVH
`define PTW_CONSTS_SVH

// address, page number and ASID widths
`define PTW_PLEN   56
`define PTW_VLEN   39
`define PTW_PPNW   44
`define PTW_ASIDW  16

// page offset and the three VPN segments
`define PTW_PGOFF    12
`define PTW_VPNSEG   9
`define PTW_VPN0_LSB 12
`define PTW_VPN1_LSB 21
`define PTW_VPN2_LSB 30

// PTEs are 8 bytes wide
`define PTW_PTE_W     64
`define PTW_PTE_SHIFT 3

`endif

// File: logic/ptw_pkg.sv
// ----------------------------------------------------------
// Sv39 walker types: widths, FSM states, PTE and port structs
// ----------------------------------------------------------
`include "ptw_consts.svh"

package ptw_pkg;

    typedef logic [`PTW_PLEN-1:0]   paddr_t;
    typedef logic [`PTW_VLEN-1:0]   vaddr_t;
    typedef logic [`PTW_PPNW-1:0]   ppn_t;
    typedef logic [`PTW_ASIDW-1:0]  asid_t;
    typedef logic [`PTW_VPNSEG-1:0] vpn_seg_t;

    typedef enum logic [2:0] {
        IDLE,
        WAIT_GRANT,
        PTE_LOOKUP,
        WAIT_RVALID,
        PROPAGATE_ERROR
    } ptw_state_e;

    // LVL1 is the root table
    typedef enum logic [1:0] {
        LVL1,
        LVL2,
        LVL3
    } ptw_lvl_e;

    typedef struct packed {
        logic [9:0] reserved;
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

    typedef struct packed {
        logic   data_req;
        paddr_t address;
    } ptw_mem_req_t;

    typedef struct packed {
        logic                  data_gnt;
        logic                  data_rvalid;
        logic [`PTW_PTE_W-1:0] data_rdata;
    } ptw_mem_rsp_t;

    typedef struct packed {
        logic is_leaf;
        logic fault;
        logic is_2m;
        logic is_1g;
    } pte_class_t;

    typedef struct packed {
        logic                              valid;
        logic [`PTW_VLEN-`PTW_PGOFF-1:0]   vpn;
        asid_t                             asid;
        logic                              is_2m;
        logic                              is_1g;
        pte_t                              content;
    } tlb_update_t;

endpackage

// File: logic/ptw_fsm.sv
// ----------------------------------------------------------
// Walk FSM: miss capture, memory request, PTE verdict, flush
// ----------------------------------------------------------
module ptw_fsm (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                flush_i,
    input  logic                itlb_access_i,
    input  logic                itlb_hit_i,
    input  logic                dtlb_access_i,
    input  logic                dtlb_hit_i,
    input  logic                rvalid_q_i,
    input  logic                data_gnt_i,
    input  ptw_pkg::pte_class_t pte_class_i,
    input  logic                at_last_lvl_i,
    output logic                data_req_o,
    output logic                capture_o,
    output logic                capture_instr_o,
    output logic                step_o,
    output logic                leaf_ok_o,
    output logic                error_o,
    output logic                active_o,
    output logic                walking_instr_o,
    output logic                itlb_miss_o,
    output logic                dtlb_miss_o
);
    import ptw_pkg::*;

    ptw_state_e state_q, state_d;
    logic       is_instr_q, is_instr_d;
    logic       dtlb_miss, itlb_miss;

    // a data miss wins, an instruction miss only with the data side quiet
    assign dtlb_miss = dtlb_access_i & ~dtlb_hit_i;
    assign itlb_miss = itlb_access_i & ~itlb_hit_i & ~dtlb_access_i;

    assign active_o        = (state_q != IDLE);
    assign walking_instr_o = is_instr_q;

    always_comb begin
        state_d         = state_q;
        is_instr_d      = is_instr_q;
        data_req_o      = 1'b0;
        capture_o       = 1'b0;
        capture_instr_o = 1'b0;
        step_o          = 1'b0;
        leaf_ok_o       = 1'b0;
        error_o         = 1'b0;
        itlb_miss_o     = 1'b0;
        dtlb_miss_o     = 1'b0;

        case (state_q)
            IDLE: begin
                is_instr_d = 1'b0;
                if (dtlb_miss && !flush_i) begin
                    capture_o   = 1'b1;
                    dtlb_miss_o = 1'b1;
                    state_d     = WAIT_GRANT;
                end else if (itlb_miss && !flush_i) begin
                    capture_o       = 1'b1;
                    capture_instr_o = 1'b1;
                    itlb_miss_o     = 1'b1;
                    is_instr_d      = 1'b1;
                    state_d         = WAIT_GRANT;
                end
            end
            WAIT_GRANT: begin
                // address is stable from the pointer register
                data_req_o = 1'b1;
                if (data_gnt_i) begin
                    state_d = PTE_LOOKUP;
                end
            end
            PTE_LOOKUP: begin
                if (rvalid_q_i) begin
                    if (pte_class_i.fault) begin
                        state_d = PROPAGATE_ERROR;
                    end else if (pte_class_i.is_leaf) begin
                        leaf_ok_o = ~flush_i;
                        state_d   = IDLE;
                    end else if (at_last_lvl_i) begin
                        // pointer with no table left below it
                        state_d = PROPAGATE_ERROR;
                    end else begin
                        step_o  = ~flush_i;
                        state_d = WAIT_GRANT;
                    end
                end
            end
            PROPAGATE_ERROR: begin
                error_o = 1'b1;
                state_d = IDLE;
            end
            WAIT_RVALID: begin
                // drain the response of a flushed walk
                if (rvalid_q_i) begin
                    state_d = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // ------------------------------------------------------------
        // flush
        // ------------------------------------------------------------
        if (flush_i) begin
            if ((state_q == PTE_LOOKUP && !rvalid_q_i) ||
                (state_q == WAIT_GRANT && data_gnt_i)) begin
                state_d = WAIT_RVALID;
            end else begin
                state_d = IDLE;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q    <= IDLE;
            is_instr_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            is_instr_q <= is_instr_d;
        end
    end

endmodule

// File: logic/ptw_level_ctr.sv
// ----------------------------------------------------------
// Walk level counter with VPN segment select and page size
// ----------------------------------------------------------
`include "ptw_consts.svh"

module ptw_level_ctr (
    input  logic              clk_i,
    input  logic              rst_ni,
    input  logic              load_i,
    input  logic              step_i,
    input  ptw_pkg::vaddr_t   vaddr_i,
    output ptw_pkg::ptw_lvl_e lvl_o,
    output ptw_pkg::vpn_seg_t vpn_seg_o,
    output logic              at_last_lvl_o,
    output logic              is_2m_o,
    output logic              is_1g_o
);
    import ptw_pkg::*;

    ptw_lvl_e lvl_q, lvl_d;

    always_comb begin
        lvl_d = lvl_q;
        if (load_i) begin
            lvl_d = LVL1;
        end else if (step_i) begin
            if (lvl_q == LVL1) begin
                lvl_d = LVL2;
            end else begin
                lvl_d = LVL3;
            end
        end
    end

    // follows the level being entered so a step sees the next table's index
    always_comb begin
        case (lvl_d)
            LVL1:    vpn_seg_o = vaddr_i[`PTW_VPN2_LSB +: `PTW_VPNSEG];
            LVL2:    vpn_seg_o = vaddr_i[`PTW_VPN1_LSB +: `PTW_VPNSEG];
            default: vpn_seg_o = vaddr_i[`PTW_VPN0_LSB +: `PTW_VPNSEG];
        endcase
    end

    assign lvl_o         = lvl_q;
    assign at_last_lvl_o = (lvl_q == LVL3);
    assign is_2m_o       = (lvl_q == LVL2);
    assign is_1g_o       = (lvl_q == LVL1);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            lvl_q <= LVL1;
        end else begin
            lvl_q <= lvl_d;
        end
    end

endmodule

// File: logic/ptw_addr_path.sv
// ----------------------------------------------------------
// Walk address path: VA, ASID and PTE pointer registers,
// and the TLB update contents
// ----------------------------------------------------------
`include "ptw_consts.svh"

module ptw_addr_path (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 capture_i,
    input  logic                 capture_instr_i,
    input  logic                 step_i,
    input  ptw_pkg::vaddr_t      itlb_vaddr_i,
    input  ptw_pkg::vaddr_t      dtlb_vaddr_i,
    input  ptw_pkg::asid_t       asid_i,
    input  ptw_pkg::ppn_t        satp_ppn_i,
    input  ptw_pkg::vpn_seg_t    vpn_seg_i,
    input  ptw_pkg::pte_t        pte_i,
    input  logic                 is_2m_i,
    input  logic                 is_1g_i,
    output ptw_pkg::vaddr_t      vaddr_o,
    output ptw_pkg::paddr_t      pptr_o,
    output ptw_pkg::tlb_update_t update_o
);
    import ptw_pkg::*;

    vaddr_t   vaddr_q;
    vaddr_t   vaddr_sel;
    asid_t    asid_q;
    paddr_t   pptr_q;
    vpn_seg_t root_seg;

    // address of whichever TLB missed
    assign vaddr_sel = capture_instr_i ? itlb_vaddr_i : dtlb_vaddr_i;
    assign root_seg  = vaddr_sel[`PTW_VPN2_LSB +: `PTW_VPNSEG];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            vaddr_q <= '0;
            asid_q  <= '0;
            pptr_q  <= '0;
        end else if (capture_i) begin
            vaddr_q <= vaddr_sel;
            asid_q  <= asid_i;
            // root table from satp, indexed by VPN[2]
            pptr_q  <= {satp_ppn_i, root_seg, {`PTW_PTE_SHIFT{1'b0}}};
        end else if (step_i) begin
            // next table from the pointer PTE
            pptr_q  <= {pte_i.ppn, vpn_seg_i, {`PTW_PTE_SHIFT{1'b0}}};
        end
    end

    assign vaddr_o = vaddr_q;
    assign pptr_o  = pptr_q;

    // ------------------------------------------------------------
    // TLB update contents, valid is steered at the top
    // ------------------------------------------------------------
    always_comb begin
        update_o         = '0;
        update_o.vpn     = vaddr_q[`PTW_VLEN-1:`PTW_PGOFF];
        update_o.asid    = asid_q;
        update_o.is_2m   = is_2m_i;
        update_o.is_1g   = is_1g_i;
        update_o.content = pte_i;
    end

endmodule

// File: logic/pte_checker.sv
// ----------------------------------------------------------
// PTE classifier: pointer, good leaf or page fault
// ----------------------------------------------------------
`include "ptw_consts.svh"

module pte_checker (
    input  ptw_pkg::pte_t       pte_i,
    input  ptw_pkg::ptw_lvl_e   lvl_i,
    input  logic                is_instr_i,
    input  logic                is_store_i,
    input  logic                mxr_i,
    output ptw_pkg::pte_class_t class_o
);
    import ptw_pkg::*;

    logic invalid;
    logic is_leaf;
    logic leaf_1g;
    logic leaf_2m;
    logic misaligned;
    logic perm_fault;

    // not valid, or the reserved w-without-r encoding
    assign invalid = ~pte_i.v | (pte_i.w & ~pte_i.r);
    assign is_leaf = pte_i.r | pte_i.x;

    assign leaf_1g = is_leaf & (lvl_i == LVL1);
    assign leaf_2m = is_leaf & (lvl_i == LVL2);

    // superpage ppn must be aligned to its size
    assign misaligned = (leaf_1g & (pte_i.ppn[2*`PTW_VPNSEG-1:0] != '0)) |
                        (leaf_2m & (pte_i.ppn[`PTW_VPNSEG-1:0] != '0));

    always_comb begin
        perm_fault = ~pte_i.a;
        if (is_instr_i) begin
            perm_fault = perm_fault | ~pte_i.x;
        end else begin
            // x-only pages are readable only with mxr
            perm_fault = perm_fault | ~(pte_i.r | (pte_i.x & mxr_i));
            if (is_store_i) begin
                perm_fault = perm_fault | ~pte_i.w | ~pte_i.d;
            end
        end
    end

    always_comb begin
        class_o         = '0;
        class_o.is_leaf = is_leaf;
        class_o.fault   = invalid | (is_leaf & (perm_fault | misaligned));
        class_o.is_2m   = leaf_2m;
        class_o.is_1g   = leaf_1g;
    end

endmodule

// File: logic/ptw_top.sv
// ----------------------------------------------------------
// Sv39 page table walker top: response register and wiring
// ----------------------------------------------------------
`include "ptw_consts.svh"

module ptw_top (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  flush_i,
    input  logic                  itlb_access_i,
    input  logic                  itlb_hit_i,
    input  logic                  dtlb_access_i,
    input  logic                  dtlb_hit_i,
    input  ptw_pkg::vaddr_t       itlb_vaddr_i,
    input  ptw_pkg::vaddr_t       dtlb_vaddr_i,
    input  ptw_pkg::asid_t        asid_i,
    input  ptw_pkg::ppn_t         satp_ppn_i,
    input  logic                  mxr_i,
    input  logic                  lsu_is_store_i,
    output ptw_pkg::ptw_mem_req_t mem_req_o,
    input  ptw_pkg::ptw_mem_rsp_t mem_rsp_i,
    output ptw_pkg::tlb_update_t  itlb_update_o,
    output ptw_pkg::tlb_update_t  dtlb_update_o,
    output ptw_pkg::vaddr_t       update_vaddr_o,
    output logic                  ptw_active_o,
    output logic                  walking_instr_o,
    output logic                  ptw_error_o,
    output logic                  itlb_miss_o,
    output logic                  dtlb_miss_o
);
    import ptw_pkg::*;

    logic                  rvalid_q;
    logic [`PTW_PTE_W-1:0] rdata_q;
    pte_t                  pte;
    pte_class_t            pte_class;
    ptw_lvl_e              lvl;
    vpn_seg_t              vpn_seg;
    vaddr_t                vaddr;
    paddr_t                pptr;
    tlb_update_t           update;
    logic data_req, capture, capture_instr, step, leaf_ok;
    logic at_last_lvl, is_2m, is_1g, walking_instr;

    // ------------------------------------------------------------
    // response register, PTE is evaluated the cycle after rvalid
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= mem_rsp_i.data_rvalid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_rsp_i.data_rvalid) begin
            rdata_q <= mem_rsp_i.data_rdata;
        end
    end

    assign pte = pte_t'(rdata_q);

    ptw_fsm ptw_fsm_inst (
        .clk_i, .rst_ni, .flush_i,
        .itlb_access_i, .itlb_hit_i, .dtlb_access_i, .dtlb_hit_i,
        .rvalid_q_i      (rvalid_q),
        .data_gnt_i      (mem_rsp_i.data_gnt),
        .pte_class_i     (pte_class),
        .at_last_lvl_i   (at_last_lvl),
        .data_req_o      (data_req),
        .capture_o       (capture),
        .capture_instr_o (capture_instr),
        .step_o          (step),
        .leaf_ok_o       (leaf_ok),
        .error_o         (ptw_error_o),
        .active_o        (ptw_active_o),
        .walking_instr_o (walking_instr),
        .itlb_miss_o, .dtlb_miss_o
    );

    ptw_level_ctr ptw_level_ctr_inst (
        .clk_i, .rst_ni,
        .load_i        (capture),
        .step_i        (step),
        .vaddr_i       (vaddr),
        .lvl_o         (lvl),
        .vpn_seg_o     (vpn_seg),
        .at_last_lvl_o (at_last_lvl),
        .is_2m_o       (is_2m),
        .is_1g_o       (is_1g)
    );

    ptw_addr_path ptw_addr_path_inst (
        .clk_i, .rst_ni,
        .capture_i       (capture),
        .capture_instr_i (capture_instr),
        .step_i          (step),
        .itlb_vaddr_i, .dtlb_vaddr_i, .asid_i, .satp_ppn_i,
        .vpn_seg_i       (vpn_seg),
        .pte_i           (pte),
        .is_2m_i         (is_2m),
        .is_1g_i         (is_1g),
        .vaddr_o         (vaddr),
        .pptr_o          (pptr),
        .update_o        (update)
    );

    pte_checker pte_checker_inst (
        .pte_i      (pte),
        .lvl_i      (lvl),
        .is_instr_i (walking_instr),
        .is_store_i (lsu_is_store_i),
        .mxr_i,
        .class_o    (pte_class)
    );

    assign mem_req_o.data_req = data_req;
    assign mem_req_o.address  = pptr;
    assign update_vaddr_o     = vaddr;
    assign walking_instr_o    = walking_instr;

    // only the TLB that missed sees the valid
    always_comb begin
        itlb_update_o       = update;
        dtlb_update_o       = update;
        itlb_update_o.valid = leaf_ok & walking_instr;
        dtlb_update_o.valid = leaf_ok & ~walking_instr;
    end

endmodule

// File: bench/ptw_sva.sv
// ----------------------------------------------------------
// Bound assertions for the walker: addresses, updates, errors
// ----------------------------------------------------------
`include "ptw_consts.svh"

module ptw_sva (
    input logic                  clk_i,
    input logic                  rst_ni,
    input ptw_pkg::vaddr_t       itlb_vaddr_i,
    input ptw_pkg::vaddr_t       dtlb_vaddr_i,
    input ptw_pkg::ppn_t         satp_ppn_i,
    input ptw_pkg::ptw_mem_req_t mem_req_o,
    input ptw_pkg::ptw_mem_rsp_t mem_rsp_i,
    input ptw_pkg::tlb_update_t  itlb_update_o,
    input ptw_pkg::tlb_update_t  dtlb_update_o,
    input logic                  ptw_active_o,
    input logic                  ptw_error_o,
    input logic                  itlb_miss_o,
    input logic                  dtlb_miss_o
);
    import ptw_pkg::*;

    // root request is satp, VPN[2], three zero bits
    root_addr_d: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dtlb_miss_o |=> mem_req_o.data_req && (mem_req_o.address ==
            {satp_ppn_i, $past(dtlb_vaddr_i[`PTW_VPN2_LSB +: `PTW_VPNSEG]), 3'b000}))
        else begin $error("data walk root address wrong"); ptw_tb.sva_errors++; end

    root_addr_i: assert property (@(posedge clk_i) disable iff (!rst_ni)
        itlb_miss_o |=> mem_req_o.data_req && (mem_req_o.address ==
            {satp_ppn_i, $past(itlb_vaddr_i[`PTW_VPN2_LSB +: `PTW_VPNSEG]), 3'b000}))
        else begin $error("instruction walk root address wrong"); ptw_tb.sva_errors++; end

    // request held with a stable address until granted
    req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_req_o.data_req && !mem_rsp_i.data_gnt |=>
            mem_req_o.data_req && $stable(mem_req_o.address))
        else begin $error("request dropped or moved before grant"); ptw_tb.sva_errors++; end

    // an outstanding read is drained even after a flush
    rsp_active: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rsp_i.data_rvalid |=> ptw_active_o)
        else begin $error("walker idle before its read response"); ptw_tb.sva_errors++; end

    upd_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (itlb_update_o.valid || dtlb_update_o.valid) |=>
            !itlb_update_o.valid && !dtlb_update_o.valid && !ptw_active_o)
        else begin $error("update not a single pulse ending the walk"); ptw_tb.sva_errors++; end

    err_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
        ptw_error_o |=> !ptw_error_o && !ptw_active_o)
        else begin $error("error not a single pulse ending the walk"); ptw_tb.sva_errors++; end

    reset_quiet: assert property (@(posedge clk_i)
        !rst_ni |-> !mem_req_o.data_req && !ptw_error_o && !ptw_active_o &&
            !itlb_update_o.valid && !dtlb_update_o.valid)
        else begin $error("outputs active during reset"); ptw_tb.sva_errors++; end

endmodule

// File: bench/ptw_tb.sv
// ----------------------------------------------------------
// Walker testbench: page-table memory model and TLB misses
// ----------------------------------------------------------
module ptw_tb;
    import ptw_pkg::*;

    localparam int TIMEOUT = 200;
    localparam logic [7:0] F_V = 8'h01, F_R = 8'h02, F_W = 8'h04, F_X = 8'h08;
    localparam logic [7:0] F_A = 8'h40, F_D = 8'h80;

    logic clk_i = 1'b0;
    logic rst_ni, flush_i, mxr_i, lsu_is_store_i;
    logic itlb_access_i, itlb_hit_i, dtlb_access_i, dtlb_hit_i;
    vaddr_t itlb_vaddr_i, dtlb_vaddr_i, update_vaddr;
    vaddr_t last_vaddr;
    asid_t asid_i;
    ppn_t satp_ppn_i;
    ptw_mem_req_t mem_req;
    ptw_mem_rsp_t mem_rsp;
    tlb_update_t itlb_upd, dtlb_upd, last_upd;
    logic active, walking_instr, ptw_error, itlb_miss, dtlb_miss;

    int errors = 0;
    int sva_errors = 0;
    int itlb_pulses, dtlb_pulses, err_pulses, itlb_miss_cnt, dtlb_miss_cnt, grant_cnt;
    logic check_instr = 1'b0;

    // sparse page-table memory and the addresses a walk must request
    logic [63:0] pt_mem [paddr_t];
    paddr_t exp_addr_q [$];
    logic req_seen, rsp_pending;
    int gnt_wait, rsp_wait;
    logic [63:0] rsp_data;

    always #4 clk_i = ~clk_i;

    ptw_top ptw_top_inst (
        .clk_i, .rst_ni, .flush_i,
        .itlb_access_i, .itlb_hit_i, .dtlb_access_i, .dtlb_hit_i,
        .itlb_vaddr_i, .dtlb_vaddr_i, .asid_i, .satp_ppn_i, .mxr_i, .lsu_is_store_i,
        .mem_req_o (mem_req), .mem_rsp_i (mem_rsp),
        .itlb_update_o (itlb_upd), .dtlb_update_o (dtlb_upd),
        .update_vaddr_o (update_vaddr), .ptw_active_o (active),
        .walking_instr_o (walking_instr), .ptw_error_o (ptw_error),
        .itlb_miss_o (itlb_miss), .dtlb_miss_o (dtlb_miss)
    );

    bind ptw_top ptw_sva ptw_sva_inst (
        .clk_i, .rst_ni, .itlb_vaddr_i, .dtlb_vaddr_i, .satp_ppn_i,
        .mem_req_o, .mem_rsp_i, .itlb_update_o, .dtlb_update_o,
        .ptw_active_o, .ptw_error_o, .itlb_miss_o, .dtlb_miss_o
    );

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    function automatic vpn_seg_t seg_of(vaddr_t va, int lvl);
        case (lvl)
            0:       return va[38:30];
            1:       return va[29:21];
            default: return va[20:12];
        endcase
    endfunction

    function automatic pte_t make_pte(ppn_t ppn, logic [7:0] flags);
        pte_t p;
        p = '0;
        p.ppn = ppn;
        {p.d, p.a, p.g, p.u, p.x, p.w, p.r, p.v} = flags;
        return p;
    endfunction

    // pointers down to the given depth, the last entry at the bottom
    task automatic build_walk(input vaddr_t va, input int levels, input pte_t last);
        ppn_t tbl;
        paddr_t a;
        pt_mem.delete();
        exp_addr_q.delete();
        tbl = satp_ppn_i;
        for (int l = 0; l < levels; l++) begin
            a = {tbl, seg_of(va, l), 3'b000};
            exp_addr_q.push_back(a);
            if (l == levels - 1) begin
                pt_mem[a] = last;
            end else begin
                tbl = tbl + 44'h11;
                pt_mem[a] = make_pte(tbl, F_V);
            end
        end
    endtask

    // ------------------------------------------------------------
    // memory model with random grant and response delays
    // ------------------------------------------------------------
    always @(posedge clk_i) begin
        #1;
        mem_rsp.data_gnt = 1'b0;
        mem_rsp.data_rvalid = 1'b0;
        if (!rst_ni) begin
            req_seen = 1'b0;
            rsp_pending = 1'b0;
        end else if (rsp_pending) begin
            if (rsp_wait == 0) begin
                mem_rsp.data_rvalid = 1'b1;
                mem_rsp.data_rdata = rsp_data;
                rsp_pending = 1'b0;
            end else begin
                rsp_wait--;
            end
        end else if (mem_req.data_req) begin
            if (!req_seen) begin
                req_seen = 1'b1;
                gnt_wait = $urandom % 4;
            end
            if (gnt_wait == 0) begin
                mem_rsp.data_gnt = 1'b1;
                req_seen = 1'b0;
                grant_cnt++;
                if (exp_addr_q.size() == 0) begin
                    $display("unexpected memory request to address %h", mem_req.address);
                    errors++;
                end else begin
                    check_val("mem_req_o.address", 64'(mem_req.address),
                              64'(exp_addr_q.pop_front()));
                end
                rsp_data = pt_mem.exists(mem_req.address) ? pt_mem[mem_req.address] : '0;
                rsp_pending = 1'b1;
                rsp_wait = $urandom % 4;
            end else begin
                gnt_wait--;
            end
        end
    end

    // pulse monitor, sampled mid-cycle
    always @(negedge clk_i) begin
        if (rst_ni) begin
            if (itlb_upd.valid) begin
                itlb_pulses++;
                last_upd = itlb_upd;
                last_vaddr = update_vaddr;
            end
            if (dtlb_upd.valid) begin
                dtlb_pulses++;
                last_upd = dtlb_upd;
                last_vaddr = update_vaddr;
            end
            if (ptw_error) err_pulses++;
            if (itlb_miss) itlb_miss_cnt++;
            if (dtlb_miss) dtlb_miss_cnt++;
            if (check_instr && active && !walking_instr) begin
                $display("walking_instr_o went low during an instruction walk at %0t", $time);
                errors++;
            end
        end
    end

    task automatic clear_counts();
        itlb_pulses = 0;
        dtlb_pulses = 0;
        err_pulses = 0;
        itlb_miss_cnt = 0;
        dtlb_miss_cnt = 0;
        grant_cnt = 0;
    endtask

    task automatic wait_idle();
        int cyc;
        cyc = 0;
        while (active && cyc < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cyc++;
        end
        if (active) begin
            $display("walker did not return to idle in time");
            errors++;
        end
    endtask

    task automatic run_walk(input logic instr, input logic both, input vaddr_t va,
                            input logic store, input logic mxr, input logic fault,
                            input logic m2, input logic g1, input pte_t last);
        int cyc;
        clear_counts();
        check_instr = instr;
        lsu_is_store_i = store;
        mxr_i = mxr;
        itlb_vaddr_i = both ? ~va : va;
        dtlb_vaddr_i = va;
        itlb_access_i = instr | both;
        dtlb_access_i = ~instr | both;
        @(posedge clk_i);
        #1;
        itlb_access_i = 1'b0;
        dtlb_access_i = 1'b0;
        cyc = 0;
        while (itlb_pulses + dtlb_pulses + err_pulses == 0 && cyc < TIMEOUT) begin
            @(posedge clk_i);
            #1;
            cyc++;
        end
        if (cyc >= TIMEOUT) begin
            $display("walk ended with neither an update nor an error");
            errors++;
        end
        wait_idle();
        repeat (2) @(posedge clk_i);
        #1;
        check_val("ptw_error_o pulses", 64'(err_pulses), 64'(fault));
        check_val("itlb_update_o.valid pulses", 64'(itlb_pulses), 64'(!fault && instr));
        check_val("dtlb_update_o.valid pulses", 64'(dtlb_pulses), 64'(!fault && !instr));
        check_val("itlb_miss_o pulses", 64'(itlb_miss_cnt), 64'(instr));
        check_val("dtlb_miss_o pulses", 64'(dtlb_miss_cnt), 64'(!instr));
        check_val("walk addresses left", 64'(exp_addr_q.size()), 64'd0);
        if (!fault) begin
            check_val("update.vpn", 64'(last_upd.vpn), 64'(va[38:12]));
            check_val("update.asid", 64'(last_upd.asid), 64'(asid_i));
            check_val("update.is_2m", 64'(last_upd.is_2m), 64'(m2));
            check_val("update.is_1g", 64'(last_upd.is_1g), 64'(g1));
            check_val("update.content", 64'(last_upd.content), 64'(last));
            check_val("update_vaddr_o", 64'(last_vaddr), 64'(va));
        end
        check_instr = 1'b0;
    endtask

    task automatic run_flush(input vaddr_t va);
        int cyc;
        clear_counts();
        build_walk(va, 3, make_pte(44'h5_5000, F_A | F_R | F_V));
        lsu_is_store_i = 1'b0;
        dtlb_vaddr_i = va;
        dtlb_access_i = 1'b1;
        @(posedge clk_i);
        #1;
        dtlb_access_i = 1'b0;
        cyc = 0;
        while (grant_cnt == 0 && cyc < TIMEOUT) begin
            @(negedge clk_i);
            cyc++;
        end
        if (grant_cnt == 0) begin
            $display("no grant seen before the flush");
            errors++;
        end
        // raised while the PTE read is still outstanding
        @(posedge clk_i);
        #1;
        flush_i = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b0;
        wait_idle();
        repeat (6) @(posedge clk_i);
        #1;
        check_val("ptw_error_o pulses after flush", 64'(err_pulses), 64'd0);
        check_val("update pulses after flush", 64'(itlb_pulses + dtlb_pulses), 64'd0);
        exp_addr_q.delete();
    endtask

    initial begin
        #(8 * 20000);
        $display("simulation watchdog expired before the tests finished");
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [63:0] rnd;
        vaddr_t va;
        void'($urandom(32'hfb1c84bb));
        rst_ni = 1'b0;
        flush_i = 1'b0;
        mxr_i = 1'b0;
        lsu_is_store_i = 1'b0;
        itlb_access_i = 1'b0;
        itlb_hit_i = 1'b0;
        dtlb_access_i = 1'b0;
        dtlb_hit_i = 1'b0;
        itlb_vaddr_i = '0;
        dtlb_vaddr_i = '0;
        asid_i = 16'h3a5c;
        satp_ppn_i = 44'h100;
        mem_rsp = '0;
        clear_counts();
        repeat (8) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #1;

        rnd = {$urandom, $urandom};
        va = rnd[38:0];
        // 4K data store through two pointers
        build_walk(va, 3, make_pte(44'h1_2345, F_D | F_A | F_W | F_R | F_V));
        run_walk(0, 0, va, 1, 0, 0, 0, 0, make_pte(44'h1_2345, F_D | F_A | F_W | F_R | F_V));
        // 2M instruction leaf
        rnd = {$urandom, $urandom};
        va = rnd[38:0];
        build_walk(va, 2, make_pte(44'h400, F_A | F_X | F_V));
        run_walk(1, 0, va, 0, 0, 0, 1, 0, make_pte(44'h400, F_A | F_X | F_V));
        // ------------------------------------------------------------
        // page faults
        // ------------------------------------------------------------
        build_walk(va, 1, '0);
        run_walk(0, 0, va, 0, 0, 1, 0, 0, '0);
        build_walk(va, 1, make_pte(44'h201, F_A | F_R | F_V));
        run_walk(0, 0, va, 0, 0, 1, 0, 0, '0);
        build_walk(va, 3, make_pte(44'h2_0000, F_A | F_W | F_R | F_V));
        run_walk(0, 0, va, 1, 0, 1, 0, 0, '0);
        build_walk(va, 1, make_pte(44'h4_0000, F_A | F_X | F_V));
        run_walk(0, 0, va, 0, 0, 1, 0, 0, '0);
        build_walk(va, 3, make_pte(44'h777, F_V));
        run_walk(0, 0, va, 0, 0, 1, 0, 0, '0);
        // x-only page becomes readable with mxr
        build_walk(va, 1, make_pte(44'h4_0000, F_A | F_X | F_V));
        run_walk(0, 0, va, 0, 1, 0, 0, 1, make_pte(44'h4_0000, F_A | F_X | F_V));
        // flush, then a normal walk
        rnd = {$urandom, $urandom};
        va = rnd[38:0];
        run_flush(va);
        build_walk(va, 3, make_pte(44'h6_0001, F_A | F_R | F_V));
        run_walk(0, 0, va, 0, 0, 0, 0, 0, make_pte(44'h6_0001, F_A | F_R | F_V));
        // both TLBs miss together
        build_walk(va, 2, make_pte(44'h800, F_A | F_R | F_V));
        run_walk(0, 1, va, 0, 0, 0, 1, 0, make_pte(44'h800, F_A | F_R | F_V));

        $display("checks done: %0d errors, %0d assertion failures", errors, sva_errors);
        if (errors + sva_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+logic
logic/ptw_pkg.sv
logic/ptw_fsm.sv
logic/ptw_level_ctr.sv
logic/ptw_addr_path.sv
logic/pte_checker.sv
logic/ptw_top.sv
bench/ptw_sva.sv
bench/ptw_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= ptw_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
